/* Makefile */
RTL = riscv_isa_pkg.sv core_ctrl_pkg.sv exec_ctrl_if.sv instr_decoder.sv \
      program_counter.sv register_file.sv execute_unit.sv load_store_unit.sv riscv_core.sv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module riscv_core $(RTL)

sim:
	verilator --binary --timing --top-module tb_riscv_core -f project.f -Mdir obj_dir
	./obj_dir/Vtb_riscv_core

clean:
	rm -rf obj_dir

/* core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B      // Operand B straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        RS1,
        PC,
        ZERO
    } src_a_e;

    typedef enum logic {
        RS2,
        IMM
    } src_b_e;

    typedef enum logic [1:0] {
        ALU,
        MEM,
        PC_PLUS4    // Link value for JAL and JALR
    } wb_sel_e;

    // Same codes as the load and store funct3 field
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } mem_size_e;

endpackage

`default_nettype wire

/* exec_ctrl_if.sv */
`default_nettype none

interface exec_ctrl_if
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
();

    alu_op_e   alu_op;
    src_a_e    src_a;
    src_b_e    src_b;
    logic      reg_write;
    wb_sel_e   wb_sel;
    logic      mem_write;
    mem_size_e mem_size;
    logic      branch;
    funct3_t   branch_funct3;   // Compare type for the branch unit
    logic      jal;
    logic      jalr;
    word_t     imm;             // Already sign-extended

    modport decoder (
        output alu_op, src_a, src_b, reg_write, wb_sel, mem_write, mem_size,
        output branch, branch_funct3, jal, jalr, imm
    );

    modport execute (input alu_op, src_a, src_b, imm, branch, branch_funct3);

    modport pc_unit (input jal, jalr, imm);

    modport mem_unit (input wb_sel, mem_write, mem_size);

endinterface

`default_nettype wire

/* execute_unit.sv */
`default_nettype none

module execute_unit
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    exec_ctrl_if.execute    ctrl,
    input  word_t           pc,
    input  word_t           rs1_data,
    input  word_t           rs2_data,
    output word_t           alu_result,
    output logic            branch_taken
);

    localparam int SHAMT_W = $clog2(XLEN);

    word_t              op_a;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    logic               cond;

    always_comb begin
        case (ctrl.src_a)
            RS1:     op_a = rs1_data;
            PC:      op_a = pc;         // AUIPC
            default: op_a = '0;
        endcase
    end

    assign op_b  = (ctrl.src_b == IMM) ? ctrl.imm : rs2_data;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << shamt;
            SLT:     alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {31'b0, op_a < op_b};
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = $signed(op_a) >>> shamt;
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            PASS_B:  alu_result = op_b;
            default: alu_result = op_a + op_b;
        endcase
    end

    // Registers compared directly, ALU stays free
    always_comb begin
        case (ctrl.branch_funct3)
            F3_BEQ:  cond = (rs1_data == rs2_data);
            F3_BNE:  cond = (rs1_data != rs2_data);
            F3_BLT:  cond = $signed(rs1_data) < $signed(rs2_data);
            F3_BGE:  cond = $signed(rs1_data) >= $signed(rs2_data);
            F3_BLTU: cond = rs1_data < rs2_data;
            F3_BGEU: cond = rs1_data >= rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.branch && cond;

endmodule

`default_nettype wire

/* instr_decoder.sv */
`default_nettype none

module instr_decoder
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  instr_t              instr,
    exec_ctrl_if.decoder        ctrl
);

    opcode_e opcode;
    funct3_t funct3;
    logic    alt_bit;       // instr[30] selects SUB or SRA
    alu_op_e arith_op;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;

    assign opcode = opcode_e'(instr[OPCODE_W-1:0]);
    assign funct3 = instr[14:12];

    // SUB only exists in the register form, ADDI has no alternate
    assign alt_bit = instr[30] && (opcode == OP);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            F3_ADD_SUB: arith_op = alt_bit ? SUB : ADD;
            F3_SLL:     arith_op = SLL;
            F3_SLT:     arith_op = SLT;
            F3_SLTU:    arith_op = SLTU;
            F3_XOR:     arith_op = XOR;
            F3_SRL_SRA: arith_op = instr[30] ? SRA : SRL;
            F3_OR:      arith_op = OR;
            F3_AND:     arith_op = AND;
            default:    arith_op = ADD;
        endcase
    end

    always_comb begin
        ctrl.alu_op        = ADD;
        ctrl.src_a         = RS1;
        ctrl.src_b         = RS2;
        ctrl.reg_write     = 1'b0;
        ctrl.wb_sel        = ALU;
        ctrl.mem_write     = 1'b0;
        ctrl.mem_size      = mem_size_e'(funct3);
        ctrl.branch        = 1'b0;
        ctrl.branch_funct3 = funct3;
        ctrl.jal           = 1'b0;
        ctrl.jalr          = 1'b0;
        ctrl.imm           = imm_i;

        case (opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op;
                ctrl.src_b     = IMM;
            end
            LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b     = IMM;           // Address is rs1 + imm
                ctrl.wb_sel    = MEM;
            end
            STORE: begin
                ctrl.src_b     = IMM;
                ctrl.imm       = imm_s;
                ctrl.mem_write = (funct3 == F3_SB) || (funct3 == F3_SH) ||
                                 (funct3 == F3_SW);
            end
            BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.imm    = imm_b;
            end
            LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a     = ZERO;
                ctrl.src_b     = IMM;
                ctrl.alu_op    = PASS_B;
                ctrl.imm       = imm_u;
            end
            AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a     = PC;
                ctrl.src_b     = IMM;
                ctrl.imm       = imm_u;
            end
            JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = PC_PLUS4;
                ctrl.jal       = 1'b1;
                ctrl.imm       = imm_j;
            end
            JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = PC_PLUS4;
                ctrl.src_b     = IMM;           // Target from the ALU sum
                ctrl.jalr      = 1'b1;
            end
            default: begin
                // Unknown opcode behaves as a no-op
            end
        endcase
    end

endmodule

`default_nettype wire

/* load_store_unit.sv */
`default_nettype none

module load_store_unit
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic            reset,
    exec_ctrl_if.mem_unit   ctrl,
    input  word_t           pc,
    input  word_t           alu_result,
    input  word_t           rs2_data,
    input  word_t           dmem_rdata,
    output word_t           dmem_addr,
    output word_t           dmem_wdata,
    output logic [3:0]      dmem_be,
    output logic            dmem_we,
    output word_t           rd_wdata
);

    logic [1:0] byte_off;
    word_t      rdata_shifted;
    word_t      load_data;

    assign dmem_addr = alu_result;
    assign byte_off  = alu_result[1:0];       // Lane select only
    assign dmem_we   = ctrl.mem_write && !reset;

    // Data copied to every lane, the enables pick the target
    always_comb begin
        case (ctrl.mem_size)
            BYTE: begin
                dmem_wdata = {4{rs2_data[7:0]}};
                dmem_be    = 4'b0001 << byte_off;
            end
            HALF: begin
                dmem_wdata = {2{rs2_data[15:0]}};
                dmem_be    = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            WORD: begin
                dmem_wdata = rs2_data;
                dmem_be    = 4'b1111;
            end
            default: begin
                dmem_wdata = rs2_data;
                dmem_be    = 4'b0000;
            end
        endcase
    end

    assign rdata_shifted = dmem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (ctrl.mem_size)
            BYTE:    load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            HALF:    load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            BYTE_U:  load_data = {24'b0, rdata_shifted[7:0]};
            HALF_U:  load_data = {16'b0, rdata_shifted[15:0]};
            default: load_data = dmem_rdata;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            MEM:      rd_wdata = load_data;
            PC_PLUS4: rd_wdata = pc + 32'd4;
            default:  rd_wdata = alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* program_counter.sv */
`default_nettype none

module program_counter
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter word_t RESET_VECTOR = '0
) (
    input  logic            clk,
    input  logic            reset,
    exec_ctrl_if.pc_unit    ctrl,
    input  logic            branch_taken,
    input  word_t           alu_result,
    output word_t           pc
);

    word_t pc_next;

    always_comb begin
        if (ctrl.jalr) begin
            pc_next = {alu_result[XLEN-1:1], 1'b0};   // rs1 + imm, bit 0 cleared
        end else if (ctrl.jal || branch_taken) begin
            pc_next = pc + ctrl.imm;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* project.f */
riscv_isa_pkg.sv
core_ctrl_pkg.sv
exec_ctrl_if.sv
instr_decoder.sv
program_counter.sv
register_file.sv
execute_unit.sv
load_store_unit.sv
riscv_core.sv
tb_riscv_core.sv

/* register_file.sv */
`default_nettype none

module register_file
    import riscv_isa_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t rd_addr,
    input  logic      we,
    input  word_t     wd,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [32];   // Entry 0 is never written

    always_ff @(posedge clk) begin
        if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= wd;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* riscv_core.sv */
`default_nettype none

module riscv_core
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter word_t RESET_VECTOR = '0
) (
    input  logic       clk,
    input  logic       reset,
    output word_t      imem_addr,
    input  instr_t     imem_rdata,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    output logic [3:0] dmem_be,
    output logic       dmem_we,
    input  word_t      dmem_rdata
);

    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    word_t     rd_wdata;
    logic      branch_taken;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;

    exec_ctrl_if ctrl_bus ();

    assign imem_addr = pc;
    assign rs1_addr  = imem_rdata[19:15];
    assign rs2_addr  = imem_rdata[24:20];
    assign rd_addr   = imem_rdata[11:7];

    instr_decoder u_decoder (
        .instr (imem_rdata),
        .ctrl  (ctrl_bus)
    );

    program_counter #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_pc (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl_bus),
        .branch_taken (branch_taken),
        .alu_result   (alu_result),
        .pc           (pc)
    );

    register_file u_regs (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .we       (ctrl_bus.reg_write),
        .wd       (rd_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit u_exec (
        .ctrl         (ctrl_bus),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    load_store_unit u_lsu (
        .reset      (reset),
        .ctrl       (ctrl_bus),
        .pc         (pc),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_we    (dmem_we),
        .rd_wdata   (rd_wdata)
    );

endmodule

`default_nettype wire

/* riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [31:0]           instr_t;   // Fixed 32-bit encoding
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [OPCODE_W-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    localparam funct3_t F3_ADD_SUB = 3'b000;   // ALU group
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;      // Branch group
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_SB = 3'b000;        // Store widths
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

endpackage

`default_nettype wire

/* tb_riscv_core.sv */
`default_nettype none

module tb_riscv_core
    import riscv_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_VECTOR = 32'h0000_0100;
    localparam int    RESET_CYCLES = 10;
    localparam int    CLK_PERIOD   = 20;

    logic       clk;
    logic       reset;
    word_t      imem_addr;
    instr_t     imem_rdata;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    logic [3:0] dmem_be;
    logic       dmem_we;
    word_t      dmem_rdata;

    instr_t imem [256];
    word_t  dmem [256];

    word_t  m_pc;                   // Reference model state
    word_t  m_regs [32];
    word_t  m_dmem [256];

    instr_t prog [$];
    int     out_off;                // Next result slot above x31
    int     prog_len;
    word_t  halt_addr;
    logic   done;

    riscv_core #(
        .RESET_VECTOR (RESET_VECTOR)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // Memory models, combinational read
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int k = 0; k < 4; k++) begin
                if (dmem_be[k]) begin
                    dmem[dmem_addr[9:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("%s is %h, expected %h", what, actual, expected));
        end
    endtask

    task automatic check_be(input logic [3:0] actual, input logic [3:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("dmem_be is %b, expected %b", actual, expected));
        end
    endtask

    function automatic instr_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                     input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
    endfunction

    function automatic instr_t enc_i(input int imm, input int rs1, input int f3, input int rd,
                                     input opcode_e op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic instr_t enc_s(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], STORE};
    endfunction

    function automatic instr_t enc_b(input int imm, input int rs1, input int rs2, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic instr_t enc_u(input word_t upper, input int rd, input opcode_e op);
        return {upper[19:0], rd[4:0], op};
    endfunction

    function automatic instr_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], JAL};
    endfunction

    task automatic emit(input instr_t ins);
        prog.push_back(ins);
    endtask

    // Result goes out through SW so it shows on the data port
    task automatic save(input int rs);
        emit(enc_s(out_off, rs, 31, 2));
        out_off += 4;
    endtask

    task automatic load_const(input int rd, input word_t val);
        word_t upper;
        upper = (val + 32'h800) >> 12;
        emit(enc_u(upper, rd, LUI));
        emit(enc_i(int'(val[11:0]), rd, 0, rd, OP_IMM));
    endtask

    task automatic build_program();
        word_t a;
        word_t b;
        word_t v;
        int    imm;
        int    f3_tab [6] = '{0, 1, 4, 5, 6, 7};
        int    t1 [6] = '{7, 7, 7, 8, 8, 7};
        int    t2 [6] = '{7, 8, 8, 7, 7, 8};
        int    n1 [6] = '{7, 7, 8, 7, 7, 8};     // Operands that fall through
        int    n2 [6] = '{8, 7, 7, 8, 8, 7};
        a = $urandom;
        b = $urandom;
        imm = int'($urandom) & 'hfff;
        emit(enc_s(0, 0, 0, 2));                        // Store fetched while in reset
        emit(enc_i('h200, 0, 0, 31, OP_IMM));           // Result area
        load_const(1, a);
        load_const(2, b);
        emit(enc_r(0, 2, 1, 0, 3)); save(3);            // ADD
        emit(enc_r('h20, 2, 1, 0, 3)); save(3);         // SUB
        emit(enc_r(0, 2, 1, 1, 3)); save(3);
        emit(enc_r(0, 2, 1, 2, 3)); save(3);
        emit(enc_r(0, 2, 1, 3, 3)); save(3);
        emit(enc_r(0, 2, 1, 4, 3)); save(3);
        emit(enc_r(0, 2, 1, 5, 3)); save(3);            // SRL
        emit(enc_r('h20, 2, 1, 5, 3)); save(3);         // SRA
        emit(enc_r(0, 2, 1, 6, 3)); save(3);
        emit(enc_r(0, 2, 1, 7, 3)); save(3);
        emit(enc_i(imm, 1, 0, 3, OP_IMM)); save(3);
        emit(enc_i(imm, 1, 2, 3, OP_IMM)); save(3);
        emit(enc_i(imm, 1, 3, 3, OP_IMM)); save(3);
        emit(enc_i(imm, 1, 4, 3, OP_IMM)); save(3);
        emit(enc_i(imm, 1, 6, 3, OP_IMM)); save(3);
        emit(enc_i(imm, 1, 7, 3, OP_IMM)); save(3);
        emit(enc_i(int'(b[4:0]), 1, 1, 3, OP_IMM)); save(3);
        emit(enc_i(int'(b[4:0]), 1, 5, 3, OP_IMM)); save(3);
        emit(enc_i('h400 | int'(b[4:0]), 1, 5, 3, OP_IMM)); save(3);
        emit(enc_u(a, 3, LUI)); save(3);
        emit(enc_u(b, 3, AUIPC)); save(3);
        // Loads from a word with mixed byte signs
        v = $urandom;
        v = {v[31:24] | 8'h80, v[23:16] & 8'h7f, v[15:8] | 8'h80, v[7:0] & 8'h7f};
        emit(enc_i('h300, 0, 0, 30, OP_IMM));
        load_const(5, v);
        emit(enc_s(0, 5, 30, 2));
        for (int off = 0; off < 4; off++) begin
            emit(enc_i(off, 30, 0, 4, LOAD)); save(4);  // LB
            emit(enc_i(off, 30, 4, 4, LOAD)); save(4);  // LBU
        end
        for (int off = 0; off < 4; off += 2) begin
            emit(enc_i(off, 30, 1, 4, LOAD)); save(4);  // LH
            emit(enc_i(off, 30, 5, 4, LOAD)); save(4);  // LHU
        end
        emit(enc_i(0, 30, 2, 4, LOAD)); save(4);
        // Partial stores, then the merged word read back
        emit(enc_i('h380, 0, 0, 29, OP_IMM));
        load_const(6, $urandom);
        for (int off = 0; off < 4; off++) begin
            emit(enc_s(off, 6, 29, 0));
        end
        emit(enc_s(0, 6, 29, 1));
        emit(enc_s(2, 6, 29, 1));
        emit(enc_s(4, 6, 29, 2));
        emit(enc_i(0, 29, 2, 4, LOAD)); save(4);
        // Branch pairs, taken then not taken; x10 counts fall-throughs
        emit(enc_i(0, 0, 0, 10, OP_IMM));
        emit(enc_i(-5, 0, 0, 7, OP_IMM));
        emit(enc_i(3, 0, 0, 8, OP_IMM));
        for (int i = 0; i < 6; i++) begin
            emit(enc_b(8, t1[i], t2[i], f3_tab[i]));
            emit(enc_i(1, 10, 0, 10, OP_IMM));
            emit(enc_b(8, n1[i], n2[i], f3_tab[i]));
            emit(enc_i(1, 10, 0, 10, OP_IMM));
        end
        save(10);
        emit(enc_j(8, 11));
        emit(enc_i(1, 10, 0, 10, OP_IMM));
        save(11);
        emit(enc_u(32'h0, 12, AUIPC));
        emit(enc_i(13, 12, 0, 13, JALR));              // Odd offset, bit 0 dropped
        emit(enc_i(1, 10, 0, 10, OP_IMM));
        save(13);
        save(10);
        emit(enc_i(123, 0, 0, 0, OP_IMM));
        emit(enc_r(0, 8, 7, 0, 0));
        save(0);
        halt_addr = RESET_VECTOR + 4 * prog.size();
        emit(enc_j(0, 0));
    endtask

    function automatic void ref_step(input instr_t ins, output logic st, output word_t st_addr,
                                     output logic [3:0] st_be, output word_t st_wdata);
        word_t      a;
        word_t      b;
        word_t      op2;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        word_t      res;
        word_t      addr;
        word_t      w;
        word_t      next_pc;
        logic [2:0] f3;
        logic       wr;
        logic       take;
        a = m_regs[ins[19:15]];
        b = m_regs[ins[24:20]];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc = m_pc + 4;
        wr = 1'b0;
        res = '0;
        st = 1'b0;
        st_addr = '0;
        st_be = '0;
        st_wdata = '0;
        case (opcode_e'(ins[6:0]))
            LUI: begin
                wr = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            AUIPC: begin
                wr = 1'b1;
                res = m_pc + {ins[31:12], 12'b0};
            end
            JAL: begin
                wr = 1'b1;
                res = m_pc + 4;
                next_pc = m_pc + imm_j;
            end
            JALR: begin
                wr = 1'b1;
                res = m_pc + 4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            BRANCH: begin
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = $signed(a) < $signed(b);
                    3'd5:    take = $signed(a) >= $signed(b);
                    3'd6:    take = a < b;
                    default: take = a >= b;
                endcase
                if (take) next_pc = m_pc + imm_b;
            end
            LOAD: begin
                wr = 1'b1;
                addr = a + imm_i;
                w = m_dmem[addr[9:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'd0:    res = {{24{w[7]}}, w[7:0]};
                    3'd1:    res = {{16{w[15]}}, w[15:0]};
                    3'd4:    res = {24'b0, w[7:0]};
                    3'd5:    res = {16'b0, w[15:0]};
                    default: res = m_dmem[addr[9:2]];
                endcase
            end
            STORE: begin
                st = 1'b1;
                st_addr = a + imm_s;
                case (f3)
                    3'd0: begin
                        st_be[st_addr[1:0]] = 1'b1;
                        st_wdata = {4{b[7:0]}};
                    end
                    3'd1: begin
                        st_be[{st_addr[1], 1'b0} +: 2] = 2'b11;
                        st_wdata = {2{b[15:0]}};
                    end
                    default: begin
                        st_be = 4'b1111;
                        st_wdata = b;
                    end
                endcase
                for (int k = 0; k < 4; k++) begin
                    if (st_be[k]) m_dmem[st_addr[9:2]][8*k +: 8] = st_wdata[8*k +: 8];
                end
            end
            OP, OP_IMM: begin
                wr = 1'b1;
                op2 = (ins[6:0] == OP) ? b : imm_i;
                case (f3)
                    3'd0:    res = (ins[6:0] == OP && ins[30]) ? a - op2 : a + op2;
                    3'd1:    res = a << op2[4:0];
                    3'd2:    res = {31'b0, $signed(a) < $signed(op2)};
                    3'd3:    res = {31'b0, a < op2};
                    3'd4:    res = a ^ op2;
                    3'd5:    res = ins[30] ? word_t'($signed(a) >>> op2[4:0]) : a >> op2[4:0];
                    3'd6:    res = a | op2;
                    default: res = a & op2;
                endcase
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = res;
        m_pc = next_pc;
    endfunction

    // Compare process, one model step per cycle
    initial begin : compare
        logic       st;
        word_t      st_addr;
        logic [3:0] st_be;
        word_t      st_wdata;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (reset) begin
                check_word(imem_addr, RESET_VECTOR, "imem_addr in reset");
                if (dmem_we !== 1'b0) report_failure("dmem_we went high during reset");
            end else if (!done) begin
                check_word(imem_addr, m_pc, "imem_addr");
                if (m_pc == halt_addr) begin
                    done = 1'b1;
                end else begin
                    ref_step(imem[m_pc[9:2]], st, st_addr, st_be, st_wdata);
                    if (dmem_we !== st) report_failure("dmem_we does not match the model");
                    if (st) begin
                        check_word(dmem_addr, st_addr, "dmem_addr");
                        check_be(dmem_be, st_be);
                        check_word(dmem_wdata, st_wdata, "dmem_wdata");
                    end
                end
            end
        end
    end

    initial begin : watchdog
        wait (prog_len != 0);
        #((RESET_CYCLES + 2 * prog_len + 2) * CLK_PERIOD);
        $display("Timeout: the program did not reach its final loop");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        done = 1'b0;
        out_off = 0;
        prog_len = 0;
        void'($urandom(32'he462a1c9));
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i(i, 0, 0, 0, OP_IMM);        // Unused slots hold distinct no-ops
            dmem[i] = (i * 32'h0101_0101) ^ 32'h5a3c_0000 ^ (i << 20);
            m_dmem[i] = dmem[i];
        end
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        build_program();
        foreach (prog[i]) begin
            imem[RESET_VECTOR[9:2] + i] = prog[i];
        end
        m_pc = RESET_VECTOR;
        prog_len = prog.size();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        wait (done);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
